// File: hdl/pc_pkg.sv
/*
 * pc selection encodings and the fixed handler addresses of the fetch stage.
 * imported by the pc mux and the stage top.
 */
`default_nettype none

package pc_pkg;

  //////////////////////////////
  // selector encodings
  //////////////////////////////

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // handler address kind when entering a trap or debug mode
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  //////////////////////////////
  // fixed addresses
  //////////////////////////////

  // debug module halt and exception entry points
  localparam logic [31:0] DM_HALT_ADDR = 32'h1A11_0800;
  localparam logic [31:0] DM_EXC_ADDR  = 32'h1A11_0808;

  // low byte of the reset vector
  localparam logic [7:0]  BOOT_OFFSET  = 8'h80;
  // low bits replaced by the vector table offset
  localparam int          VEC_BASE_LSB = 8;
  localparam int          IRQ_VEC_W    = 5;

endpackage

`default_nettype wire

// File: hdl/fetch_pkg.sv
/*
 * bus and queue sizing for the fetch path, plus the address and word types.
 */
`default_nettype none

package fetch_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] word_t;

  // instruction queue entries and bus requests in flight
  localparam int FIFO_DEPTH      = 2;
  localparam int MAX_OUTSTANDING = 2;

  // counter width, wide enough for queue entries plus requests in flight
  localparam int CNT_W = $clog2(FIFO_DEPTH + MAX_OUTSTANDING + 1);

  // every instruction is a full word
  localparam int INSTR_BYTES = 4;

endpackage

`default_nettype wire

// File: hdl/fetch_if.sv
/*
 * valid/ready channel from the prefetch queue to the IF-ID register.
 * one instruction moves on each edge with valid and ready high.
 */
`default_nettype none

interface fetch_if import fetch_pkg::*; ();

  logic  valid;
  logic  ready;
  // instruction word, its address and the bus error flag
  word_t rdata;
  addr_t addr;
  logic  err;

  // prefetch queue side
  modport source (
    output valid, rdata, addr, err,
    input  ready
  );

  // pipeline register side
  modport sink (
    input  valid, rdata, addr, err,
    output ready
  );

endinterface

`default_nettype wire

// File: hdl/pc_select.sv
/*
 * next fetch address mux and trap vector generation.
 * purely combinational, result is used in the same cycle as pc_set_i.
 */
`default_nettype none

module pc_select import pc_pkg::*, fetch_pkg::*; (
  input  logic                 pc_set_i,
  input  pc_sel_e              pc_mux_i,
  input  exc_pc_sel_e          exc_pc_mux_i,
  input  logic                 irq_int_i,
  input  logic [IRQ_VEC_W-1:0] irq_vec_i,
  input  addr_t                boot_addr_i,
  input  addr_t                branch_target_ex_i,
  input  addr_t                csr_mepc_i,
  input  addr_t                csr_depc_i,
  input  addr_t                csr_mtvec_i,
  output addr_t                fetch_addr_o,
  output logic                 csr_mtvec_init_o
);

  logic [IRQ_VEC_W-1:0] irq_vec;
  addr_t                exc_pc;
  addr_t                boot_pc;
  addr_t                fetch_addr_n;

  // internal interrupts all share the nmi slot, the top vector
  assign irq_vec = irq_int_i ? {IRQ_VEC_W{1'b1}} : irq_vec_i;

  assign boot_pc = {boot_addr_i[ADDR_W-1:VEC_BASE_LSB], BOOT_OFFSET};

  //////////////////////////////
  // handler address
  //////////////////////////////

  always_comb begin
    unique case (exc_pc_mux_i)
      // table base with a zero low byte
      EXC_PC_EXC: exc_pc = {csr_mtvec_i[ADDR_W-1:VEC_BASE_LSB], {VEC_BASE_LSB{1'b0}}};
      // one word per vector number
      EXC_PC_IRQ: exc_pc = {csr_mtvec_i[ADDR_W-1:VEC_BASE_LSB],
                            {(VEC_BASE_LSB - IRQ_VEC_W - 2){1'b0}}, irq_vec, 2'b00};
      EXC_PC_DBD:     exc_pc = DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = DM_EXC_ADDR;
      default:        exc_pc = {csr_mtvec_i[ADDR_W-1:VEC_BASE_LSB], {VEC_BASE_LSB{1'b0}}};
    endcase
  end

  //////////////////////////////
  // fetch address
  //////////////////////////////

  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: fetch_addr_n = boot_pc;
      PC_JUMP: fetch_addr_n = branch_target_ex_i;
      PC_EXC:  fetch_addr_n = exc_pc;
      // back from trap handler
      PC_ERET: fetch_addr_n = csr_mepc_i;
      // back from debug mode
      PC_DRET: fetch_addr_n = csr_depc_i;
      default: fetch_addr_n = boot_pc;
    endcase
  end

  // word fetches only, drop the byte offset
  assign fetch_addr_o = {fetch_addr_n[ADDR_W-1:2], 2'b00};

  // csr file loads its mtvec reset value on the boot redirect
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

endmodule

`default_nettype wire

// File: hdl/prefetch_buffer.sv
/*
 * word prefetcher on the req/gnt/rvalid instruction bus.
 * keeps up to two requests in flight and a two entry queue towards IF-ID,
 * responses to requests issued before a branch are dropped.
 */
`default_nettype none

module prefetch_buffer import fetch_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    req_i,
  input  logic    branch_i,
  input  addr_t   branch_addr_i,
  output logic    instr_req_o,
  output addr_t   instr_addr_o,
  input  logic    instr_gnt_i,
  input  logic    instr_rvalid_i,
  input  word_t   instr_rdata_i,
  input  logic    instr_bus_err_i,
  fetch_if.source fetch,
  output logic    busy_o
);

  // bus side state
  addr_t                      fetch_addr_q;
  addr_t                      resp_addr_q;
  logic [CNT_W-1:0]           out_cnt_q, out_cnt_n;
  logic [MAX_OUTSTANDING-1:0] discard_q, discard_n;
  logic [CNT_W-1:0]           fill;
  logic                       req_gnt;
  logic                       resp_keep;

  // queue, entry 0 is the head
  word_t                      q_rdata_q [FIFO_DEPTH];
  word_t                      q_rdata_n [FIFO_DEPTH];
  addr_t                      q_addr_q  [FIFO_DEPTH];
  addr_t                      q_addr_n  [FIFO_DEPTH];
  logic [FIFO_DEPTH-1:0]      q_err_q, q_err_n;
  logic [CNT_W-1:0]           q_cnt_q, q_cnt_n;
  logic                       q_pop;

  //////////////////////////////
  // request generation
  //////////////////////////////

  assign fill = q_cnt_q + out_cnt_q;

  always_comb begin
    if (branch_i) begin
      // old queue is flushed, only the bus limit applies
      instr_req_o = req_i & (out_cnt_q < CNT_W'(MAX_OUTSTANDING));
    end else begin
      // back-pressure, never ask for more than the queue can hold
      instr_req_o = req_i & (fill < CNT_W'(FIFO_DEPTH));
    end
  end

  // redirect address goes out in the same cycle
  assign instr_addr_o = branch_i ? branch_addr_i : fetch_addr_q;
  assign req_gnt      = instr_req_o & instr_gnt_i;

  //////////////////////////////
  // outstanding tracking
  //////////////////////////////

  // oldest request in bit 0, responses come back in order
  always_comb begin
    out_cnt_n = out_cnt_q;
    discard_n = discard_q;
    if (instr_rvalid_i) begin
      out_cnt_n = out_cnt_q - 1'b1;
      discard_n = discard_q >> 1;
    end
    // everything still on the bus belongs to the old path
    if (branch_i) begin
      discard_n = '1;
    end
    if (req_gnt) begin
      for (int i = 0; i < MAX_OUTSTANDING; i++) begin
        if (CNT_W'(i) == out_cnt_n) begin
          discard_n[i] = 1'b0;
        end
      end
      out_cnt_n = out_cnt_n + 1'b1;
    end
  end

  // a response in the branch cycle is stale as well
  assign resp_keep = instr_rvalid_i & ~discard_q[0] & ~branch_i;

  //////////////////////////////
  // instruction queue
  //////////////////////////////

  assign q_pop = fetch.valid & fetch.ready;

  always_comb begin
    q_rdata_n = q_rdata_q;
    q_addr_n  = q_addr_q;
    q_err_n   = q_err_q;
    q_cnt_n   = q_cnt_q;
    // shift down on pop
    if (q_pop) begin
      for (int i = 0; i < FIFO_DEPTH - 1; i++) begin
        q_rdata_n[i] = q_rdata_q[i+1];
        q_addr_n[i]  = q_addr_q[i+1];
        q_err_n[i]   = q_err_q[i+1];
      end
      q_cnt_n = q_cnt_q - 1'b1;
    end
    // write behind the last valid entry
    if (resp_keep) begin
      for (int i = 0; i < FIFO_DEPTH; i++) begin
        if (CNT_W'(i) == q_cnt_n) begin
          q_rdata_n[i] = instr_rdata_i;
          q_addr_n[i]  = resp_addr_q;
          q_err_n[i]   = instr_bus_err_i;
        end
      end
      q_cnt_n = q_cnt_n + 1'b1;
    end
    if (branch_i) begin
      q_cnt_n = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_addr_q <= '0;
      resp_addr_q  <= '0;
      out_cnt_q    <= '0;
      discard_q    <= '0;
      q_cnt_q      <= '0;
      q_err_q      <= '0;
      for (int i = 0; i < FIFO_DEPTH; i++) begin
        q_rdata_q[i] <= '0;
        q_addr_q[i]  <= '0;
      end
    end else begin
      // next word to request
      if (req_gnt) begin
        fetch_addr_q <= instr_addr_o + addr_t'(INSTR_BYTES);
      end else if (branch_i) begin
        fetch_addr_q <= branch_addr_i;
      end
      // address of the next kept response
      if (branch_i) begin
        resp_addr_q <= branch_addr_i;
      end else if (resp_keep) begin
        resp_addr_q <= resp_addr_q + addr_t'(INSTR_BYTES);
      end
      out_cnt_q <= out_cnt_n;
      discard_q <= discard_n;
      q_cnt_q   <= q_cnt_n;
      q_rdata_q <= q_rdata_n;
      q_addr_q  <= q_addr_n;
      q_err_q   <= q_err_n;
    end
  end

  // head of queue towards IF-ID, valid only from stored entries
  assign fetch.valid = (q_cnt_q != '0);
  assign fetch.rdata = q_rdata_q[0];
  assign fetch.addr  = q_addr_q[0];
  assign fetch.err   = q_err_q[0];

  assign busy_o = (out_cnt_q != '0);

endmodule

`default_nettype wire

// File: hdl/if_id_reg.sv
/*
 * IF-ID pipeline register with the valid and new flags.
 * also checks that sequential instructions arrive at pc + 4.
 */
`default_nettype none

module if_id_reg import fetch_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  fetch_if.sink fetch,
  input  logic  id_in_ready_i,
  input  logic  pc_set_i,
  input  logic  instr_valid_clear_i,
  output logic  instr_valid_id_o,
  output logic  instr_new_id_o,
  output word_t instr_rdata_id_o,
  output logic  instr_fetch_err_o,
  output addr_t pc_if_o,
  output addr_t pc_id_o,
  output logic  pc_mismatch_alert_o
);

  logic  take;
  logic  valid_d;
  logic  seq_q, seq_d;
  addr_t pc_id_incr;

  // ID takes whenever it is ready
  assign fetch.ready = id_in_ready_i;
  assign take        = fetch.valid & id_in_ready_i;

  // a redirect squashes the word taken in the same cycle
  // valid then holds until ID clears it
  assign valid_d = (take & ~pc_set_i) | (instr_valid_id_o & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o <= 1'b0;
      instr_new_id_o   <= 1'b0;
    end else begin
      instr_valid_id_o <= valid_d;
      // one cycle pulse per capture
      instr_new_id_o   <= take;
    end
  end

  // pipeline registers, frozen while ID stalls
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_rdata_id_o  <= '0;
      instr_fetch_err_o <= 1'b0;
      pc_id_o           <= '0;
    end else if (take) begin
      instr_rdata_id_o  <= fetch.rdata;
      instr_fetch_err_o <= fetch.err;
      pc_id_o           <= fetch.addr;
    end
  end

  assign pc_if_o = fetch.addr;

  //////////////////////////////
  // pc consistency
  //////////////////////////////

  // no check after reset, a redirect or a faulting fetch
  assign seq_d = (seq_q | take) & ~pc_set_i & ~(fetch.valid & fetch.err);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_q <= 1'b0;
    end else begin
      seq_q <= seq_d;
    end
  end

  assign pc_id_incr = pc_id_o + addr_t'(INSTR_BYTES);

  // offered word must follow the one held in ID
  assign pc_mismatch_alert_o = seq_q & fetch.valid & (fetch.addr != pc_id_incr);

endmodule

`default_nettype wire

// File: hdl/if_stage.sv
/*
 * instruction fetch stage top.
 * pc mux, prefetch buffer and IF-ID register, with the bus as plain ports.
 */
`default_nettype none

module if_stage import pc_pkg::*, fetch_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  addr_t                boot_addr_i,
  // instruction bus
  output logic                 instr_req_o,
  output addr_t                instr_addr_o,
  input  logic                 instr_gnt_i,
  input  logic                 instr_rvalid_i,
  input  word_t                instr_rdata_i,
  input  logic                 instr_bus_err_i,
  // towards ID
  output logic                 instr_valid_id_o,
  output logic                 instr_new_id_o,
  output word_t                instr_rdata_id_o,
  output logic                 instr_fetch_err_o,
  output addr_t                pc_if_o,
  output addr_t                pc_id_o,
  // control from ID/EX and CSRs
  input  logic                 instr_valid_clear_i,
  input  logic                 pc_set_i,
  input  pc_sel_e              pc_mux_i,
  input  exc_pc_sel_e          exc_pc_mux_i,
  input  logic                 irq_int_i,
  input  logic [IRQ_VEC_W-1:0] irq_vec_i,
  input  addr_t                branch_target_ex_i,
  input  addr_t                csr_mepc_i,
  input  addr_t                csr_depc_i,
  input  addr_t                csr_mtvec_i,
  output logic                 csr_mtvec_init_o,
  input  logic                 id_in_ready_i,
  output logic                 pc_mismatch_alert_o,
  output logic                 if_busy_o
);

  addr_t fetch_addr_n;

  // queue head to pipeline register
  fetch_if fetch_bus ();

  pc_select u_pc_select (
    .pc_set_i           (pc_set_i),
    .pc_mux_i           (pc_mux_i),
    .exc_pc_mux_i       (exc_pc_mux_i),
    .irq_int_i          (irq_int_i),
    .irq_vec_i          (irq_vec_i),
    .boot_addr_i        (boot_addr_i),
    .branch_target_ex_i (branch_target_ex_i),
    .csr_mepc_i         (csr_mepc_i),
    .csr_depc_i         (csr_depc_i),
    .csr_mtvec_i        (csr_mtvec_i),
    .fetch_addr_o       (fetch_addr_n),
    .csr_mtvec_init_o   (csr_mtvec_init_o)
  );

  prefetch_buffer u_prefetch_buffer (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .branch_i        (pc_set_i),
    .branch_addr_i   (fetch_addr_n),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_rdata_i   (instr_rdata_i),
    .instr_bus_err_i (instr_bus_err_i),
    .fetch           (fetch_bus.source),
    .busy_o          (if_busy_o)
  );

  if_id_reg u_if_id_reg (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch               (fetch_bus.sink),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_if_o             (pc_if_o),
    .pc_id_o             (pc_id_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

endmodule

`default_nettype wire

// File: sim/tb_clk_gen.sv
/*
 * clock and reset for the fetch stage testbench.
 * 40 ns clock, reset held low for the first three rising edges.
 */
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_PERIOD = 20;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // release just after the third edge, away from the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    #2;
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// File: sim/tb_if_stage.sv
/*
 * fetch stage testbench. a memory model answers the bus with random delays,
 * an ID model stalls and clears at random, and every new instruction in ID
 * is checked against the expected PC, word and error flag.
 */
`default_nettype none

module tb_if_stage import pc_pkg::*, fetch_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          DRIVE_DLY    = 2;
  localparam logic [31:0] LFSR_SEED    = 32'hb51b_2a07;
  localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;
  localparam int          TOTAL_INSTRS = 4 + 12 + 8 + 16 + 12 + 7 * 8;
  localparam int          WDOG_CYCLES  = 40;

  // redirect sources of which several are not word aligned
  localparam addr_t BOOT_ADDR  = 32'h0000_1234;
  localparam addr_t JUMP_ADDR  = 32'h0000_3002;
  localparam addr_t MEPC_ADDR  = 32'h0000_5006;
  localparam addr_t DEPC_ADDR  = 32'h0000_6abd;
  localparam addr_t MTVEC_ADDR = 32'h0000_4001;
  // words here answer with a bus error
  localparam addr_t ERR_LO     = 32'h0000_12c0;
  localparam addr_t ERR_HI     = 32'h0000_12c8;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 req_i;
  addr_t                boot_addr_i;
  logic                 instr_req_o;
  addr_t                instr_addr_o;
  logic                 instr_gnt_i;
  logic                 instr_rvalid_i;
  word_t                instr_rdata_i;
  logic                 instr_bus_err_i;
  logic                 instr_valid_id_o;
  logic                 instr_new_id_o;
  word_t                instr_rdata_id_o;
  logic                 instr_fetch_err_o;
  addr_t                pc_if_o;
  addr_t                pc_id_o;
  logic                 instr_valid_clear_i;
  logic                 pc_set_i;
  pc_sel_e              pc_mux_i;
  exc_pc_sel_e          exc_pc_mux_i;
  logic                 irq_int_i;
  logic [IRQ_VEC_W-1:0] irq_vec_i;
  addr_t                branch_target_ex_i;
  addr_t                csr_mepc_i;
  addr_t                csr_depc_i;
  addr_t                csr_mtvec_i;
  logic                 csr_mtvec_init_o;
  logic                 id_in_ready_i;
  logic                 pc_mismatch_alert_o;
  logic                 if_busy_o;

  // testbench state
  logic [31:0] lfsr_q = LFSR_SEED;
  addr_t       pend_q[$];
  addr_t       exp_pc;
  int          n_seen = 0;
  int          errors = 0;
  logic        slow_id = 1'b0;
  string       test_name = "reset";
  // a boot redirect is driven in this cycle
  logic        boot_set = 1'b0;
  // values seen in the previous cycle
  logic        valid_prev = 1'b0;
  logic        clear_prev = 1'b0;
  logic        set_prev   = 1'b0;
  addr_t       pc_if_prev = '0;
  logic        exp_valid;

  tb_clk_gen u_clk_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  if_stage dut (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .req_i               (req_i),
    .boot_addr_i         (boot_addr_i),
    .instr_req_o         (instr_req_o),
    .instr_addr_o        (instr_addr_o),
    .instr_gnt_i         (instr_gnt_i),
    .instr_rvalid_i      (instr_rvalid_i),
    .instr_rdata_i       (instr_rdata_i),
    .instr_bus_err_i     (instr_bus_err_i),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_if_o             (pc_if_o),
    .pc_id_o             (pc_id_o),
    .instr_valid_clear_i (instr_valid_clear_i),
    .pc_set_i            (pc_set_i),
    .pc_mux_i            (pc_mux_i),
    .exc_pc_mux_i        (exc_pc_mux_i),
    .irq_int_i           (irq_int_i),
    .irq_vec_i           (irq_vec_i),
    .branch_target_ex_i  (branch_target_ex_i),
    .csr_mepc_i          (csr_mepc_i),
    .csr_depc_i          (csr_depc_i),
    .csr_mtvec_i         (csr_mtvec_i),
    .csr_mtvec_init_o    (csr_mtvec_init_o),
    .id_in_ready_i       (id_in_ready_i),
    .pc_mismatch_alert_o (pc_mismatch_alert_o),
    .if_busy_o           (if_busy_o)
  );

  //////////////////////////////
  // models and reference
  //////////////////////////////

  // galois lfsr stepped once per bit
  function automatic logic rand_bit();
    logic lsb;
    lsb    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (lsb) begin
      lfsr_q = lfsr_q ^ LFSR_TAPS;
    end
    return lsb;
  endfunction

  // memory content depends on every address bit
  function automatic word_t mem_word(addr_t a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h6b2d_0f13;
  endfunction

  function automatic logic in_err_window(addr_t a);
    return (a >= ERR_LO) && (a < ERR_HI);
  endfunction

  // first PC after a redirect
  function automatic addr_t exp_target(pc_sel_e sel, exc_pc_sel_e esel, logic irq_int,
                                       logic [IRQ_VEC_W-1:0] vec);
    addr_t                tgt;
    logic [IRQ_VEC_W-1:0] num;
    addr_t                tbase;
    num   = irq_int ? 5'd31 : vec;
    tbase = {csr_mtvec_i[31:8], 8'h00};
    case (sel)
      PC_BOOT: tgt = {boot_addr_i[31:8], 8'h80};
      PC_JUMP: tgt = branch_target_ex_i;
      PC_ERET: tgt = csr_mepc_i;
      PC_DRET: tgt = csr_depc_i;
      PC_EXC: begin
        case (esel)
          EXC_PC_EXC: tgt = tbase;
          // four bytes per vector
          EXC_PC_IRQ: tgt = tbase + addr_t'(num) * 4;
          EXC_PC_DBD: tgt = DM_HALT_ADDR;
          default:    tgt = DM_EXC_ADDR;
        endcase
      end
      default: tgt = {boot_addr_i[31:8], 8'h80};
    endcase
    return tgt & ~32'h3;
  endfunction

  task automatic report_mismatch(string what, logic [31:0] expv, logic [31:0] actv);
    $display("[ERROR] %s: %s expected %h actual %h", test_name, what, expv, actv);
    errors++;
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  // one cycle of bus and ID model activity
  task automatic drive_cycle();
    @(posedge clk_i);
    #DRIVE_DLY;
    pc_set_i    = 1'b0;
    boot_set    = 1'b0;
    instr_gnt_i = rand_bit();
    if (pend_q.size() > 0 && rand_bit()) begin
      instr_rvalid_i  = 1'b1;
      instr_rdata_i   = mem_word(pend_q[0]);
      instr_bus_err_i = in_err_window(pend_q[0]);
    end else begin
      instr_rvalid_i  = 1'b0;
      instr_rdata_i   = '0;
      instr_bus_err_i = 1'b0;
    end
    id_in_ready_i = rand_bit();
    if (slow_id) begin
      id_in_ready_i = id_in_ready_i & rand_bit();
    end
    // ID consumes what it holds now and then
    instr_valid_clear_i = instr_valid_id_o & rand_bit();
  endtask

  // ID stalls and flushes in the redirect cycle
  task automatic redirect(string name, pc_sel_e sel, exc_pc_sel_e esel, logic irq_int,
                          logic [IRQ_VEC_W-1:0] vec);
    drive_cycle();
    test_name           = name;
    req_i               = 1'b1;
    pc_set_i            = 1'b1;
    boot_set            = (sel == PC_BOOT);
    pc_mux_i            = sel;
    exc_pc_mux_i        = esel;
    irq_int_i           = irq_int;
    irq_vec_i           = vec;
    id_in_ready_i       = 1'b0;
    instr_valid_clear_i = 1'b1;
  endtask

  task automatic run_instrs(string name, int count);
    int target;
    test_name = name;
    target    = n_seen + count;
    while (n_seen < target) begin
      drive_cycle();
    end
  endtask

  initial begin
    req_i               = 1'b0;
    boot_addr_i         = BOOT_ADDR;
    instr_gnt_i         = 1'b0;
    instr_rvalid_i      = 1'b0;
    instr_rdata_i       = '0;
    instr_bus_err_i     = 1'b0;
    instr_valid_clear_i = 1'b0;
    pc_set_i            = 1'b0;
    pc_mux_i            = PC_BOOT;
    exc_pc_mux_i        = EXC_PC_EXC;
    irq_int_i           = 1'b0;
    irq_vec_i           = '0;
    branch_target_ex_i  = JUMP_ADDR;
    csr_mepc_i          = MEPC_ADDR;
    csr_depc_i          = DEPC_ADDR;
    csr_mtvec_i         = MTVEC_ADDR;
    id_in_ready_i       = 1'b0;
    @(posedge rst_ni);
    @(negedge clk_i);
    if (instr_req_o) report_mismatch("instr_req_o", 0, instr_req_o);
    if (instr_valid_id_o) report_mismatch("instr_valid_id_o", 0, instr_valid_id_o);
    if (instr_new_id_o) report_mismatch("instr_new_id_o", 0, instr_new_id_o);
    if (if_busy_o) report_mismatch("if_busy_o", 0, if_busy_o);
    // boot run passes the error window and then stalls ID harder
    redirect("boot", PC_BOOT, EXC_PC_EXC, 1'b0, '0);
    run_instrs("boot", 4);
    run_instrs("sequential", 12);
    run_instrs("bus_error", 8);
    slow_id = 1'b1;
    run_instrs("back_pressure", 16);
    slow_id = 1'b0;
    redirect("jump", PC_JUMP, EXC_PC_EXC, 1'b0, '0);
    run_instrs("jump", 12);
    redirect("exception", PC_EXC, EXC_PC_EXC, 1'b0, '0);
    run_instrs("exception", 8);
    redirect("interrupt", PC_EXC, EXC_PC_IRQ, 1'b0, 5'd5);
    run_instrs("interrupt", 8);
    redirect("internal_irq", PC_EXC, EXC_PC_IRQ, 1'b1, 5'd3);
    run_instrs("internal_irq", 8);
    redirect("debug_entry", PC_EXC, EXC_PC_DBD, 1'b0, '0);
    run_instrs("debug_entry", 8);
    redirect("debug_exception", PC_EXC, EXC_PC_DBG_EXC, 1'b0, '0);
    run_instrs("debug_exception", 8);
    redirect("mret", PC_ERET, EXC_PC_EXC, 1'b0, '0);
    run_instrs("mret", 8);
    redirect("dret", PC_DRET, EXC_PC_EXC, 1'b0, '0);
    run_instrs("dret", 8);
    $display("checked %0d instructions, %0d errors", n_seen, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  //////////////////////////////
  // bus tracking and checks
  //////////////////////////////

  // sampled mid-cycle where inputs and outputs have settled
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (instr_req_o && pend_q.size() >= MAX_OUTSTANDING) begin
        $display("[ERROR] %s: bus request issued with %0d requests already in flight",
                 test_name, pend_q.size());
        errors++;
      end
      // busy while any granted request still waits for its response
      if (if_busy_o != (pend_q.size() != 0)) begin
        report_mismatch("if_busy_o", pend_q.size() != 0, if_busy_o);
      end
      if (instr_rvalid_i) begin
        void'(pend_q.pop_front());
      end
      if (instr_req_o && instr_gnt_i) begin
        pend_q.push_back(instr_addr_o);
      end
      // valid rises on a capture outside a redirect and holds until cleared
      exp_valid = (instr_new_id_o & ~set_prev) | (valid_prev & ~clear_prev);
      if (instr_valid_id_o != exp_valid) begin
        report_mismatch("instr_valid_id_o", exp_valid, instr_valid_id_o);
      end
      // ID model receives a new instruction
      if (instr_new_id_o) begin
        if (pc_id_o != exp_pc) report_mismatch("pc_id_o", exp_pc, pc_id_o);
        // address offered by the queue in the capture cycle
        if (pc_if_prev != exp_pc) report_mismatch("pc_if_o", exp_pc, pc_if_prev);
        if (instr_fetch_err_o != in_err_window(exp_pc)) begin
          report_mismatch("instr_fetch_err_o", in_err_window(exp_pc), instr_fetch_err_o);
        end
        if (!in_err_window(exp_pc) && instr_rdata_id_o != mem_word(exp_pc)) begin
          report_mismatch("instr_rdata_id_o", mem_word(exp_pc), instr_rdata_id_o);
        end
        exp_pc = exp_pc + 32'd4;
        n_seen++;
      end
      if (pc_mismatch_alert_o) report_mismatch("pc_mismatch_alert_o", 0, pc_mismatch_alert_o);
      if (csr_mtvec_init_o != boot_set) begin
        report_mismatch("csr_mtvec_init_o", boot_set, csr_mtvec_init_o);
      end
      if (pc_set_i) begin
        exp_pc = exp_target(pc_mux_i, exc_pc_mux_i, irq_int_i, irq_vec_i);
      end
      valid_prev = instr_valid_id_o;
      clear_prev = instr_valid_clear_i;
      set_prev   = pc_set_i;
      pc_if_prev = pc_if_o;
    end
  end

  // watchdog with a budget of cycles per instruction
  initial begin
    repeat (TOTAL_INSTRS * WDOG_CYCLES) @(posedge clk_i);
    $display("timeout in %s: %0d of %0d instructions arrived", test_name, n_seen,
             TOTAL_INSTRS);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
hdl/pc_pkg.sv
hdl/fetch_pkg.sv
hdl/fetch_if.sv
hdl/pc_select.sv
hdl/prefetch_buffer.sv
hdl/if_id_reg.sv
hdl/if_stage.sv
sim/tb_clk_gen.sv
sim/tb_if_stage.sv

// File: run.sh
#!/bin/sh
# build and run the fetch stage testbench with Verilator
# exit status is non-zero when the build fails or the testbench reports failure

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal -j 0 --top-module tb_if_stage \
  -f files.f -o tb_if_stage > build.log 2>&1 \
  && ./obj_dir/tb_if_stage > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Test failures found" sim.log && exit 1
exit 0
